//--- compile.f
rtl/pov_pkg.sv
rtl/polar_frame_ram.sv
rtl/fb_arbiter.sv
rtl/host_write_port.sv
rtl/column_fetcher.sv
rtl/column_formatter.sv
rtl/hub75_scanner.sv
rtl/pov_display_top.sv
testbench/tb_pov_display.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal -j 0
TOP      = tb_pov_display
FILELIST = compile.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/tb_pov_display.sv
module tb_pov_display
  import pov_pkg::*;
;

  localparam int TIMEOUT_CYCLES = 40000; // About five times the full run.
  localparam int NUM_A = 6;
  localparam int NUM_B = 4;

  typedef struct packed {
    half_col_t        lower;
    half_col_t        upper;
    logic [RAD_W-1:0] addr;
  } exp_col_t;

  logic               clk_in = 1'b0;
  logic               rst_in;
  logic [THETA_W-1:0] theta;
  logic               wr_valid;
  logic [THETA_W-1:0] wr_addr;
  slot_t              wr_slot;
  logic               wr_busy;
  hub75_t             pins;

  slot_t       ref_mem [ROT_RES];
  exp_col_t    exp_q [$];
  int          exp_idx_q [$];
  logic [31:0] lcg_state = 32'd94738;
  int          errors = 0;
  int          checks = 0;
  int          col_count = 0;  // Latched columns since reset.
  int          arm0_count = 0;
  int          cycle_cnt = 0;
  int          post_rst = 0;
  int          pix_cnt = 0;
  logic        sclk_q = 1'b0;
  half_col_t   cap_lower;
  half_col_t   cap_upper;

  // Slot pairs of the two sets never overlap.
  logic [THETA_W-1:0] set_a [NUM_A] = '{10'd3, 10'd100, 10'd257, 10'd400, 10'd511, 10'd777};
  logic [THETA_W-1:0] set_b [NUM_B] = '{10'd20, 10'd150, 10'd300, 10'd480};

  pov_display_top i_pov_display_top (
    .clk_in   (clk_in),
    .rst_in   (rst_in),
    .theta    (theta),
    .wr_valid (wr_valid),
    .wr_addr  (wr_addr),
    .wr_slot  (wr_slot),
    .wr_busy  (wr_busy),
    .pins     (pins)
  );

  always #2 clk_in = ~clk_in;

  function automatic logic [31:0] lcg_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic slot_t random_slot();
    slot_t       s;
    logic [31:0] r;
    s.column[31:0]          = lcg_rand();
    s.column[NUM_ROWS-1:32] = lcg_rand();
    r                       = lcg_rand();
    s.radius                = r[20:16];
    return s;
  endfunction

  // Arm 0 lands on the upper half at its radius; arm 1 sits half a turn on,
  // lands on the lower half, and its scan line is mirrored.
  function automatic exp_col_t expected_column(input logic [THETA_W-1:0] th, input bit arm);
    exp_col_t  e;
    slot_t     s;
    half_col_t words;
    s = arm ? ref_mem[th + THETA_W'(ROT_RES / 2)] : ref_mem[th];
    for (int i = 0; i < NUM_ROWS; i++) begin
      words[i] = s.column[i] ? {RGB_RES{1'b1}} : {RGB_RES{1'b0}};
    end
    if (arm) begin
      e.lower = words;
      e.upper = '0;
      e.addr  = RAD_W'(SCAN_RATE - 1 - int'(s.radius));
    end else begin
      e.lower = '0;
      e.upper = words;
      e.addr  = s.radius;
    end
    return e;
  endfunction

  task automatic check_idle_pins(input string when);
    if (pins.latch || pins.sclk || !pins.oe || wr_busy) begin
      errors++;
      $display("MISMATCH at %0t: panel pins or wr_busy not idle %s", $time, when);
    end
  endtask

  task automatic write_slot(input logic [THETA_W-1:0] addr, input slot_t s);
    while (wr_busy) begin
      @(posedge clk_in);
      #1;
    end
    wr_valid      = 1'b1;
    wr_addr       = addr;
    wr_slot       = s;
    ref_mem[addr] = s;
    @(posedge clk_in);
    #1;
    wr_valid = 1'b0;
    if (!wr_busy) begin
      errors++;
      $display("MISMATCH at %0t: wr_busy low after a write to slot %0d", $time, addr);
    end
  endtask

  task automatic wait_write_done();
    while (wr_busy) begin
      @(posedge clk_in);
      #1;
    end
  endtask

  // Rewrites set B with random gaps while fetches keep running.
  task automatic rewrite_slots_spread();
    int gap;
    foreach (set_b[i]) begin
      gap = int'(lcg_rand() % 64);
      repeat (gap) begin
        @(posedge clk_in);
        #1;
      end
      write_slot(set_b[i], random_slot());
      write_slot(set_b[i] + THETA_W'(ROT_RES / 2), random_slot());
    end
    wait_write_done();
  endtask

  // Change theta just after an arm 0 latch; the pair after the current one
  // is then the one fetched for th.
  task automatic show_theta(input logic [THETA_W-1:0] th);
    int seen;
    seen = arm0_count;
    while (arm0_count == seen) begin
      @(posedge clk_in);
      #1;
    end
    theta = th;
    exp_q.push_back(expected_column(th, 1'b0));
    exp_idx_q.push_back(col_count + 1);
    exp_q.push_back(expected_column(th, 1'b1));
    exp_idx_q.push_back(col_count + 2);
  endtask

  task automatic compare_column();
    exp_col_t e;
    int       bad;
    if ((exp_idx_q.size() != 0) && (exp_idx_q[0] == col_count)) begin
      e = exp_q.pop_front();
      bad = exp_idx_q.pop_front();
      checks++;
      if (pix_cnt != NUM_ROWS) begin
        errors++;
        $display("MISMATCH at %0t: column %0d got %0d sclk pulses, expected %0d",
                 $time, col_count, pix_cnt, NUM_ROWS);
      end
      if (pins.addr !== e.addr) begin
        errors++;
        $display("MISMATCH at %0t: column %0d addr %0d, expected %0d",
                 $time, col_count, pins.addr, e.addr);
      end
      bad = -1;
      for (int i = NUM_ROWS - 1; i >= 0; i--) begin
        if ((cap_lower[i] !== e.lower[i]) || (cap_upper[i] !== e.upper[i])) begin
          bad = i;
        end
      end
      if (bad >= 0) begin
        errors++;
        $display("MISMATCH at %0t: column %0d pixel %0d rgb0/rgb1 %h/%h, expected %h/%h",
                 $time, col_count, bad, cap_lower[bad], cap_upper[bad],
                 e.lower[bad], e.upper[bad]);
      end
    end
  endtask

  // Panel capture.
  always @(posedge clk_in) begin
    if (rst_in) begin
      post_rst = 0;
      pix_cnt  = 0;
    end else begin
      post_rst++;
      if ((post_rst > 1) && (pins.oe != pins.latch)) begin
        errors++;
        $display("MISMATCH at %0t: oe is not high only during latch", $time);
      end
      if (pins.sclk && !sclk_q) begin
        if (pix_cnt < NUM_ROWS) begin
          cap_lower[pix_cnt] = pins.rgb0;
          cap_upper[pix_cnt] = pins.rgb1;
        end
        pix_cnt++;
      end
      if (pins.latch) begin
        compare_column();
        pix_cnt = 0;
        if (col_count % 2 == 0) begin
          arm0_count++;
        end
        col_count++;
      end
    end
    sclk_q = pins.sclk;
  end

  always @(posedge clk_in) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("ERROR: run hung, not finished after %0d cycles", cycle_cnt);
      $display("errors: %0d  columns checked: %0d", errors + 1, checks);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    rst_in   = 1'b1;
    theta    = '0;
    wr_valid = 1'b0;
    wr_addr  = '0;
    wr_slot  = '0;
    repeat (10) begin
      @(posedge clk_in);
      #1;
      check_idle_pins("in reset");
    end
    rst_in = 1'b0;
    @(posedge clk_in);
    #1;
    if (pins.latch || pins.sclk || wr_busy) begin
      errors++;
      $display("MISMATCH at %0t: latch, sclk or wr_busy active just after reset", $time);
    end

    foreach (set_a[i]) begin
      write_slot(set_a[i], random_slot());
      write_slot(set_a[i] + THETA_W'(ROT_RES / 2), random_slot());
    end
    foreach (set_b[i]) begin
      write_slot(set_b[i], random_slot());
      write_slot(set_b[i] + THETA_W'(ROT_RES / 2), random_slot());
    end
    wait_write_done();

    foreach (set_a[i]) begin
      show_theta(set_a[i]);
    end
    for (int i = 0; i < NUM_B; i++) begin
      show_theta(set_b[i]);
      show_theta(set_a[NUM_A - 1 - i]);
    end

    fork
      foreach (set_a[i]) begin
        show_theta(set_a[i]);
      end
      rewrite_slots_spread();
    join
    foreach (set_b[i]) begin
      show_theta(set_b[i]); // Must show the rewritten data.
    end

    while (exp_q.size() != 0) begin
      @(posedge clk_in);
      #1;
    end
    $display("errors: %0d  columns checked: %0d", errors, checks);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- rtl/pov_display_top.sv
module pov_display_top
  import pov_pkg::*;
(
  input  logic               clk_in,
  input  logic               rst_in,
  input  logic [THETA_W-1:0] theta,
  input  logic               wr_valid,
  input  logic [THETA_W-1:0] wr_addr,
  input  slot_t              wr_slot,
  output logic               wr_busy,
  output hub75_t             pins
);

  logic       host_req;
  logic       host_gnt;
  ram_req_t   host_cmd;
  logic       fetch_req;
  logic       fetch_gnt;
  ram_req_t   fetch_cmd;
  ram_req_t   ram_cmd;
  slot_t      rd_slot;
  arm_pair_t  pair;
  logic       pair_valid;
  panel_col_t col;
  logic       col_valid;
  logic       last;

  host_write_port i_host_write_port (
    .clk_in   (clk_in),
    .rst_in   (rst_in),
    .wr_valid (wr_valid),
    .wr_addr  (wr_addr),
    .wr_slot  (wr_slot),
    .gnt      (host_gnt),
    .req      (host_req),
    .cmd      (host_cmd),
    .wr_busy  (wr_busy)
  );

  column_fetcher i_column_fetcher (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .theta      (theta),
    .gnt        (fetch_gnt),
    .rd_slot    (rd_slot),
    .req        (fetch_req),
    .cmd        (fetch_cmd),
    .pair       (pair),
    .pair_valid (pair_valid)
  );

  fb_arbiter i_fb_arbiter (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .fetch_req (fetch_req),
    .fetch_cmd (fetch_cmd),
    .host_req  (host_req),
    .host_cmd  (host_cmd),
    .fetch_gnt (fetch_gnt),
    .host_gnt  (host_gnt),
    .ram_cmd   (ram_cmd)
  );

  polar_frame_ram i_polar_frame_ram (
    .clk_in  (clk_in),
    .req     (ram_cmd),
    .rd_slot (rd_slot)
  );

  column_formatter i_column_formatter (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .pair       (pair),
    .pair_valid (pair_valid),
    .last       (last),
    .col        (col),
    .col_valid  (col_valid)
  );

  hub75_scanner i_hub75_scanner (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .col       (col),
    .col_valid (col_valid),
    .pins      (pins),
    .last      (last)
  );

endmodule

//--- rtl/hub75_scanner.sv
module hub75_scanner
  import pov_pkg::*;
(
  input  logic       clk_in,
  input  logic       rst_in,
  input  panel_col_t col,
  input  logic       col_valid,
  output hub75_t     pins,
  output logic       last
);

  typedef enum logic [1:0] {
    S_INIT,
    S_IDLE,
    S_SHIFT,
    S_LATCH
  } scan_state_t;

  scan_state_t                 state;
  panel_col_t                  col_q;
  logic [$clog2(NUM_ROWS)-1:0] pix;
  logic                        phase; // High on the sclk rise clock.

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= S_INIT;
      pix   <= '0;
      phase <= 1'b0;
      pins  <= '0;
      pins.oe <= 1'b1; // Blanked in reset.
      last  <= 1'b0;
    end else begin
      last       <= 1'b0;
      pins.latch <= 1'b0;
      pins.oe    <= 1'b0;
      case (state)
        S_INIT: begin
          last  <= 1'b1; // Kicks off the formatter.
          state <= S_IDLE;
        end
        S_IDLE: begin
          if (col_valid) begin
            pins.rgb0 <= col.lower[0];
            pins.rgb1 <= col.upper[0];
            pins.sclk <= 1'b0;
            pix       <= '0;
            phase     <= 1'b1;
            state     <= S_SHIFT;
          end
        end
        S_SHIFT: begin
          if (phase) begin
            pins.sclk <= 1'b1;
            phase     <= 1'b0;
          end else if (pix == NUM_ROWS - 1) begin
            pins.sclk  <= 1'b0;
            pins.addr  <= col_q.col_num;
            pins.latch <= 1'b1;
            pins.oe    <= 1'b1;
            state      <= S_LATCH;
          end else begin
            pins.rgb0 <= col_q.lower[pix + 1'b1];
            pins.rgb1 <= col_q.upper[pix + 1'b1];
            pins.sclk <= 1'b0;
            pix       <= pix + 1'b1;
            phase     <= 1'b1;
          end
        end
        S_LATCH: begin
          last  <= 1'b1;
          state <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if ((state == S_IDLE) && col_valid) begin
      col_q <= col;
    end
  end

endmodule

//--- rtl/column_formatter.sv
module column_formatter
  import pov_pkg::*;
(
  input  logic       clk_in,
  input  logic       rst_in,
  input  arm_pair_t  pair,
  input  logic       pair_valid,
  input  logic       last,
  output panel_col_t col,
  output logic       col_valid
);

  typedef enum logic [1:0] {
    IDLE,
    COL0,
    COL1
  } fmt_state_t;

  fmt_state_t state;
  arm_pair_t  held;
  arm_pair_t  cur_pair;

  // Each on bit becomes a full-scale colour word.
  function automatic half_col_t widen(input logic [NUM_ROWS-1:0] bits);
    half_col_t words;
    for (int i = 0; i < NUM_ROWS; i++) begin
      words[i] = {RGB_RES{bits[i]}};
    end
    return words;
  endfunction

  // Take a pair arriving on the same cycle as last.
  assign cur_pair = pair_valid ? pair : held;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state     <= IDLE;
      col_valid <= 1'b0;
    end else begin
      col_valid <= 1'b0;
      case (state)
        IDLE: begin
          if (last) begin
            state     <= COL0;
            col_valid <= 1'b1;
          end
        end
        COL0: begin
          if (last) begin
            state     <= COL1;
            col_valid <= 1'b1;
          end
        end
        COL1:    state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (state == IDLE) begin
      held <= cur_pair;
      if (last) begin
        col.col_num <= cur_pair.arm0.radius; // Arm 0 on the upper half.
        col.lower   <= '0;
        col.upper   <= widen(cur_pair.arm0.column);
      end
    end else if ((state == COL0) && last) begin
      // Arm 1 points the other way, so its radius is mirrored.
      col.col_num <= RAD_W'(SCAN_RATE - 1) - held.arm1.radius;
      col.lower   <= widen(held.arm1.column);
      col.upper   <= '0;
    end
  end

endmodule

//--- rtl/column_fetcher.sv
module column_fetcher
  import pov_pkg::*;
(
  input  logic               clk_in,
  input  logic               rst_in,
  input  logic [THETA_W-1:0] theta,
  input  logic               gnt,
  input  slot_t              rd_slot,
  output logic               req,
  output ram_req_t           cmd,
  output arm_pair_t          pair,
  output logic               pair_valid
);

  typedef enum logic [1:0] {
    F_IDLE,
    F_RD1,
    F_WAIT
  } fetch_state_t;

  fetch_state_t       state;
  logic [THETA_W-1:0] theta_q;
  logic [THETA_W-1:0] last_theta;
  logic               primed;   // A fetch has run since reset.
  logic               changed;
  logic               rd_pend;  // RAM data belongs to us this cycle.
  logic               rd_sel;   // Which arm the next return fills.

  assign changed = !primed || (theta_q != last_theta);

  // Fetcher has top priority, so every request cycle is granted.
  always_comb begin
    req      = ((state == F_IDLE) && changed) || (state == F_RD1);
    cmd.we   = 1'b0;
    cmd.data = '0;
    if (state == F_RD1) begin
      cmd.addr = last_theta + THETA_W'(ROT_RES / 2); // Wraps mod ROT_RES.
    end else begin
      cmd.addr = theta_q;
    end
  end

  always_ff @(posedge clk_in) begin
    theta_q <= theta;
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state      <= F_IDLE;
      last_theta <= '0;
      primed     <= 1'b0;
      rd_pend    <= 1'b0;
      rd_sel     <= 1'b0;
      pair_valid <= 1'b0;
    end else begin
      pair_valid <= 1'b0;
      rd_pend    <= gnt;
      case (state)
        F_IDLE: begin
          if (changed) begin
            last_theta <= theta_q;
            primed     <= 1'b1;
            state      <= F_RD1;
          end
        end
        F_RD1:   state <= F_WAIT;
        F_WAIT: begin
          if (rd_pend && rd_sel) begin
            state <= F_IDLE; // New theta is checked again here.
          end
        end
        default: state <= F_IDLE;
      endcase
      if (rd_pend) begin
        rd_sel     <= !rd_sel;
        pair_valid <= rd_sel;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (rd_pend && !rd_sel) begin
      pair.arm0 <= rd_slot;
    end
    if (rd_pend && rd_sel) begin
      pair.arm1 <= rd_slot;
    end
  end

endmodule

//--- rtl/host_write_port.sv
module host_write_port
  import pov_pkg::*;
(
  input  logic               clk_in,
  input  logic               rst_in,
  input  logic               wr_valid,
  input  logic [THETA_W-1:0] wr_addr,
  input  slot_t              wr_slot,
  input  logic               gnt,
  output logic               req,
  output ram_req_t           cmd,
  output logic               wr_busy
);

  logic pending;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      pending <= 1'b0;
    end else if (gnt) begin
      pending <= 1'b0; // Written this cycle.
    end else if (wr_valid) begin
      pending <= 1'b1;
    end
  end

  always_ff @(posedge clk_in) begin
    if (wr_valid && !pending) begin
      cmd.we   <= 1'b1;
      cmd.addr <= wr_addr;
      cmd.data <= wr_slot;
    end
  end

  assign req     = pending;
  assign wr_busy = pending;

endmodule

//--- rtl/fb_arbiter.sv
module fb_arbiter
  import pov_pkg::*;
(
  input  logic     clk_in,
  input  logic     rst_in,
  input  logic     fetch_req,
  input  ram_req_t fetch_cmd,
  input  logic     host_req,
  input  ram_req_t host_cmd,
  output logic     fetch_gnt,
  output logic     host_gnt,
  output ram_req_t ram_cmd
);

  logic host_ok;

  // Host drops req the cycle after its grant, so skip it while granted.
  assign host_ok = host_req && !host_gnt;

  // Grant and command are registered together; the RAM sees the command
  // in the grant cycle, and the read data follows one cycle later.
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      fetch_gnt  <= 1'b0;
      host_gnt   <= 1'b0;
      ram_cmd.we <= 1'b0;
    end else begin
      fetch_gnt <= fetch_req;               // Fetcher always wins.
      host_gnt  <= host_ok && !fetch_req;
      if (fetch_req) begin
        ram_cmd    <= fetch_cmd;
        ram_cmd.we <= 1'b0;
      end else if (host_ok) begin
        ram_cmd <= host_cmd;
      end else begin
        ram_cmd.we <= 1'b0;                 // Idle cycle, no write.
      end
    end
  end

endmodule

//--- rtl/polar_frame_ram.sv
module polar_frame_ram
  import pov_pkg::*;
(
  input  logic     clk_in,
  input  ram_req_t req,
  output slot_t    rd_slot
);

  slot_t mem [ROT_RES];

  // Single port: a write cycle produces no read data.
  always_ff @(posedge clk_in) begin
    if (req.we) begin
      mem[req.addr] <= req.data;
    end else begin
      rd_slot <= mem[req.addr]; // Valid one cycle later.
    end
  end

endmodule

//--- rtl/pov_pkg.sv
package pov_pkg;

  localparam int ROT_RES   = 1024; // Angle slots per turn.
  localparam int THETA_W   = 10;
  localparam int SCAN_RATE = 32;   // Scan lines per panel half.
  localparam int RAD_W     = 5;
  localparam int NUM_ROWS  = 64;   // Pixels per column.
  localparam int RGB_RES   = 9;

  // One half of a panel column, one colour word per pixel.
  typedef logic [NUM_ROWS-1:0][RGB_RES-1:0] half_col_t;

  typedef struct packed {
    logic [RAD_W-1:0]    radius;
    logic [NUM_ROWS-1:0] column;
  } slot_t;

  typedef struct packed {
    logic               we;
    logic [THETA_W-1:0] addr;
    slot_t              data;
  } ram_req_t;

  typedef struct packed {
    slot_t arm1;
    slot_t arm0;
  } arm_pair_t;

  typedef struct packed {
    logic [RAD_W-1:0] col_num;
    half_col_t        lower; // Goes out on rgb0.
    half_col_t        upper; // Goes out on rgb1.
  } panel_col_t;

  typedef struct packed {
    logic [RGB_RES-1:0] rgb0;
    logic [RGB_RES-1:0] rgb1;
    logic [RAD_W-1:0]   addr;
    logic               sclk;
    logic               latch;
    logic               oe;
  } hub75_t;

endpackage
